//--- hw/chess_pkg.sv
package chess_pkg;

	typedef logic color_t;

	localparam color_t WHITE = 1'b0;
	localparam color_t BLACK = 1'b1;

	typedef enum logic [2:0] {
		EMPTY  = 3'o0,
		PAWN   = 3'o1,
		KNIGHT = 3'o2,
		BISHOP = 3'o3,
		ROOK   = 3'o4,
		QUEEN  = 3'o5,
		KING   = 3'o6
	} piece_t;

	typedef struct packed {
		color_t color;
		piece_t piece;
	} square_t;

	typedef logic [2:0] file_idx_t;   // file a is 0
	typedef logic [2:0] row_idx_t;    // row 1 is 0
	typedef logic [5:0] coord_t;      // {file, row}, e1 = 6'o40

	typedef square_t [7:0] rank_t;    // [0] is file a, in the low bits
	typedef rank_t [7:0] board_t;     // [0] is row 1
	typedef logic [7:0] enp_rights_t; // bit 0 is file a

	typedef struct packed {
		rank_t       rank1;
		rank_t       rank5;
		logic        castle_left;
		logic        castle_right;
		enp_rights_t enp;
	} position_t;

	localparam row_idx_t RANK1_ROW = 3'd0;
	localparam row_idx_t RANK5_ROW = 3'd4;
	localparam row_idx_t RANK6_ROW = 3'd5; // landing row of a white en passant capture

	localparam file_idx_t FILE_A = 3'd0;
	localparam file_idx_t FILE_B = 3'd1;
	localparam file_idx_t FILE_C = 3'd2;
	localparam file_idx_t FILE_D = 3'd3;
	localparam file_idx_t FILE_E = 3'd4;
	localparam file_idx_t FILE_F = 3'd5;
	localparam file_idx_t FILE_G = 3'd6;
	localparam file_idx_t FILE_H = 3'd7;

	// true when the square holds exactly this piece of this color
	function automatic logic square_is(square_t sq, color_t c, piece_t p);
		return (sq.color == c) && (sq.piece == p);
	endfunction

endpackage

//--- hw/move_pkg.sv
package move_pkg;

	// flag field of a move word, msb first
	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn_move;
		logic pawn_double;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	typedef struct packed {
		move_flags_t       flags;
		chess_pkg::coord_t from;
		chess_pkg::coord_t to;
	} move_t;

	localparam int SLOTS = 8;

	// slot 0 sits just below the padding byte
	typedef struct packed {
		logic [7:0]             pad;
		move_t [0:SLOTS-1]      slot;
	} move_bundle_t;

	localparam move_flags_t CASTLE_FLAGS = 7'b0000010;
	localparam move_flags_t ENP_FLAGS    = 7'b0010101; // pawn move, en passant, capture

	localparam move_t INVALID_MOVE = '{
		flags: 7'b1000000,
		from:  6'o00,
		to:    6'o00
	};

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_AW    = 2;

	typedef enum logic [1:0] {
		ST_CAPTURE = 2'd0,
		ST_CASTLE  = 2'd1,
		ST_ENP     = 2'd2,
		ST_DONE    = 2'd3
	} seq_state_t;

endpackage

//--- hw/position_latch.sv
`timescale 1ns/1ps

module position_latch (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    capture,
	input  chess_pkg::board_t       board,
	input  logic                    castle_left,
	input  logic                    castle_right,
	input  chess_pkg::enp_rights_t  enp_rights,
	output chess_pkg::position_t    pos
);

	chess_pkg::position_t pos_next;

	// only the first and fifth rows matter for the special moves
	always_comb begin
		pos_next.rank1        = board[chess_pkg::RANK1_ROW];
		pos_next.rank5        = board[chess_pkg::RANK5_ROW];
		pos_next.castle_left  = castle_left;
		pos_next.castle_right = castle_right;
		pos_next.enp          = enp_rights;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= '0; // white empty squares, no rights
		end else if (capture) begin
			pos <= pos_next;
		end
	end

endmodule

//--- hw/castle_finder.sv
`timescale 1ns/1ps

module castle_finder (
	input  chess_pkg::position_t     pos,
	output move_pkg::move_bundle_t   castle_bundle,
	output logic                     castle_found
);

	localparam chess_pkg::coord_t E1 = {chess_pkg::FILE_E, chess_pkg::RANK1_ROW};
	localparam chess_pkg::coord_t G1 = {chess_pkg::FILE_G, chess_pkg::RANK1_ROW};
	localparam chess_pkg::coord_t C1 = {chess_pkg::FILE_C, chess_pkg::RANK1_ROW};

	chess_pkg::rank_t r1;
	logic king_home;
	logic kingside;
	logic queenside;

	assign r1 = pos.rank1;

	// no check or attacked-square test here
	assign king_home = chess_pkg::square_is(r1[chess_pkg::FILE_E], chess_pkg::WHITE, chess_pkg::KING);

	assign kingside = king_home && pos.castle_right
		&& (r1[chess_pkg::FILE_F].piece == chess_pkg::EMPTY)
		&& (r1[chess_pkg::FILE_G].piece == chess_pkg::EMPTY)
		&& chess_pkg::square_is(r1[chess_pkg::FILE_H], chess_pkg::WHITE, chess_pkg::ROOK);

	assign queenside = king_home && pos.castle_left
		&& (r1[chess_pkg::FILE_B].piece == chess_pkg::EMPTY)
		&& (r1[chess_pkg::FILE_C].piece == chess_pkg::EMPTY)
		&& (r1[chess_pkg::FILE_D].piece == chess_pkg::EMPTY)
		&& chess_pkg::square_is(r1[chess_pkg::FILE_A], chess_pkg::WHITE, chess_pkg::ROOK);

	always_comb begin
		castle_bundle = '0;
		for (int i = 0; i < move_pkg::SLOTS; i++) begin
			castle_bundle.slot[i] = move_pkg::INVALID_MOVE;
		end
		if (kingside)
			castle_bundle.slot[0] = {move_pkg::CASTLE_FLAGS, E1, G1};
		if (queenside)
			castle_bundle.slot[1] = {move_pkg::CASTLE_FLAGS, E1, C1};
	end

	assign castle_found = kingside | queenside;

endmodule

//--- hw/en_passant_finder.sv
`timescale 1ns/1ps

module en_passant_finder (
	input  chess_pkg::position_t     pos,
	output move_pkg::move_bundle_t   enp_bundle,
	output logic                     enp_found
);

	chess_pkg::rank_t r5;

	assign r5 = pos.rank5;

	always_comb begin
		int lo;
		int hi;
		int tgt;
		logic tgt_valid;
		chess_pkg::file_idx_t tgt_file;

		enp_bundle = '0;
		enp_found  = 1'b0;
		for (int i = 0; i < move_pkg::SLOTS; i++) begin
			enp_bundle.slot[i] = move_pkg::INVALID_MOVE;
		end

		// files pair up as (a,b) (c,d) (e,f) (g,h), slots 2k and 2k+1 per pair
		for (int k = 0; k < 4; k++) begin
			lo        = 2 * k;
			hi        = 2 * k + 1;
			tgt       = lo;
			tgt_valid = 1'b0;

			// both files of a pair can't really carry a double step, lower file wins
			if (pos.enp[lo] && chess_pkg::square_is(r5[lo], chess_pkg::BLACK, chess_pkg::PAWN)) begin
				tgt       = lo;
				tgt_valid = 1'b1;
			end else if (pos.enp[hi]
				&& chess_pkg::square_is(r5[hi], chess_pkg::BLACK, chess_pkg::PAWN)) begin
				tgt       = hi;
				tgt_valid = 1'b1;
			end
			tgt_file = chess_pkg::file_idx_t'(tgt);

			if (tgt_valid) begin
				// capturing pawn on the left neighbour
				if (tgt > 0
					&& chess_pkg::square_is(r5[tgt-1], chess_pkg::WHITE, chess_pkg::PAWN)) begin
					enp_bundle.slot[lo] = {move_pkg::ENP_FLAGS,
						chess_pkg::file_idx_t'(tgt - 1), chess_pkg::RANK5_ROW,
						tgt_file, chess_pkg::RANK6_ROW};
					enp_found = 1'b1;
				end
				// and on the right neighbour
				if (tgt < 7
					&& chess_pkg::square_is(r5[tgt+1], chess_pkg::WHITE, chess_pkg::PAWN)) begin
					enp_bundle.slot[hi] = {move_pkg::ENP_FLAGS,
						chess_pkg::file_idx_t'(tgt + 1), chess_pkg::RANK5_ROW,
						tgt_file, chess_pkg::RANK6_ROW};
					enp_found = 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/move_sequencer.sv
`timescale 1ns/1ps

module move_sequencer (
	input  logic                     clk,
	input  logic                     reset,
	input  move_pkg::move_bundle_t   castle_bundle,
	input  logic                     castle_found,
	input  move_pkg::move_bundle_t   enp_bundle,
	input  logic                     enp_found,
	output logic                     capture,
	output logic                     wr_en,
	output move_pkg::move_bundle_t   wr_data,
	output logic                     done
);

	move_pkg::seq_state_t state;
	move_pkg::seq_state_t state_next;

	move_pkg::move_bundle_t enp_bundle_q;
	logic enp_valid_q; // high only in ST_ENP

	always_comb begin
		state_next = state;
		case (state)
			move_pkg::ST_CAPTURE: state_next = move_pkg::ST_CASTLE;
			move_pkg::ST_CASTLE:  state_next = move_pkg::ST_ENP;
			move_pkg::ST_ENP:     state_next = move_pkg::ST_DONE;
			move_pkg::ST_DONE:    state_next = move_pkg::ST_DONE; // hold until reset
			default:              state_next = move_pkg::ST_CAPTURE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= move_pkg::ST_CAPTURE;
			enp_valid_q <= 1'b0;
		end else begin
			state       <= state_next;
			enp_valid_q <= (state == move_pkg::ST_CASTLE) && enp_found;
		end
	end

	// en passant result trails the castling write by one stage
	always_ff @(posedge clk) begin
		if (state == move_pkg::ST_CASTLE)
			enp_bundle_q <= enp_bundle;
	end

	assign capture = (state == move_pkg::ST_CAPTURE);

	// castling goes straight from the finder, en passant from the stage register
	assign wr_en = ((state == move_pkg::ST_CASTLE) && castle_found) || enp_valid_q;

	assign wr_data = (state == move_pkg::ST_CASTLE) ? castle_bundle : enp_bundle_q;

	assign done = (state == move_pkg::ST_DONE);

endmodule

//--- hw/move_fifo.sv
`timescale 1ns/1ps

module move_fifo (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     wr_en,
	input  move_pkg::move_bundle_t   wr_data,
	input  logic                     rd_en,
	output move_pkg::move_bundle_t   fifo_out,
	output logic                     fifo_empty
);

	move_pkg::move_bundle_t mem [move_pkg::FIFO_DEPTH];

	logic [move_pkg::FIFO_AW-1:0] wr_ptr;
	logic [move_pkg::FIFO_AW-1:0] rd_ptr;
	logic [move_pkg::FIFO_AW:0]   count;

	logic full;
	logic do_write;
	logic do_read;

	assign full       = count[move_pkg::FIFO_AW]; // depth is a power of two
	assign fifo_empty = (count == '0);

	assign do_write = wr_en && !full;       // dropped when full
	assign do_read  = rd_en && !fifo_empty; // ignored when empty

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= wr_data;
	end

	// show-ahead, head is always on the output
	assign fifo_out = mem[rd_ptr];

endmodule

//--- hw/move_gen_top.sv
`timescale 1ns/1ps

module move_gen_top (
	input  logic                     clk,
	input  logic                     reset,
	input  chess_pkg::board_t        board,
	input  logic                     castle_left,
	input  logic                     castle_right,
	input  chess_pkg::enp_rights_t   enp_rights,
	input  logic                     rd_en,
	output move_pkg::move_bundle_t   fifo_out,
	output logic                     fifo_empty,
	output logic                     done
);

	logic                   capture;
	chess_pkg::position_t   pos;
	move_pkg::move_bundle_t castle_bundle;
	logic                   castle_found;
	move_pkg::move_bundle_t enp_bundle;
	logic                   enp_found;
	logic                   wr_en;
	move_pkg::move_bundle_t wr_data;

	position_latch u_latch (
		.clk          (clk),
		.reset        (reset),
		.capture      (capture),
		.board        (board),
		.castle_left  (castle_left),
		.castle_right (castle_right),
		.enp_rights   (enp_rights),
		.pos          (pos)
	);

	castle_finder u_castle (.pos(pos), .castle_bundle(castle_bundle), .castle_found(castle_found));

	en_passant_finder u_enp (.pos(pos), .enp_bundle(enp_bundle), .enp_found(enp_found));

	move_sequencer u_seq (
		.clk           (clk),
		.reset         (reset),
		.castle_bundle (castle_bundle),
		.castle_found  (castle_found),
		.enp_bundle    (enp_bundle),
		.enp_found     (enp_found),
		.capture       (capture),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.done          (done)
	);

	move_fifo u_fifo (
		.clk        (clk),
		.reset      (reset),
		.wr_en      (wr_en),
		.wr_data    (wr_data),
		.rd_en      (rd_en),
		.fifo_out   (fifo_out),
		.fifo_empty (fifo_empty)
	);

endmodule

//--- testbench/tb_move_gen.sv
`timescale 1ns/1ps

module tb_move_gen;

	localparam int NUM_POS        = 200;
	localparam int CYCLES_PER_POS = 30;

	logic                   clk = 1'b0;
	logic                   reset;
	chess_pkg::board_t      board;
	logic                   castle_left;
	logic                   castle_right;
	chess_pkg::enp_rights_t enp_rights;
	logic                   rd_en;
	move_pkg::move_bundle_t fifo_out;
	logic                   fifo_empty;
	logic                   done;

	integer seed;
	int     n_errors;
	int     n_checks;
	bit     check_go; // stimulus hands the read phase to the checker
	move_pkg::move_bundle_t exp_q[$];

	move_gen_top DUT (
		.clk          (clk),
		.reset        (reset),
		.board        (board),
		.castle_left  (castle_left),
		.castle_right (castle_right),
		.enp_rights   (enp_rights),
		.rd_en        (rd_en),
		.fifo_out     (fifo_out),
		.fifo_empty   (fifo_empty),
		.done         (done)
	);

	always #5 clk = ~clk;

	task automatic report_bundle(string name, logic [159:0] exp, logic [159:0] got);
		n_errors++;
		$display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
	endtask

	task automatic report_bit(string name, logic exp, logic got);
		n_errors++;
		$display("ERR %0t %s exp=%b got=%b", $time, name, exp, got);
	endtask

	function automatic int unsigned rand_below(int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic chess_pkg::square_t make_square(chess_pkg::color_t c, chess_pkg::piece_t p);
		chess_pkg::square_t s;
		s.color = c;
		s.piece = p;
		return s;
	endfunction

	function automatic chess_pkg::square_t random_square();
		return make_square(chess_pkg::color_t'(rand_below(2)), chess_pkg::piece_t'(rand_below(7)));
	endfunction

	// expected bundles straight from the castling and en passant rules
	function automatic void ref_bundles(input chess_pkg::board_t b, input logic cl, input logic cr,
		input chess_pkg::enp_rights_t er, output move_pkg::move_bundle_t cb,
		output move_pkg::move_bundle_t eb, output logic cf, output logic ef);
		move_pkg::move_t bad;
		chess_pkg::rank_t r1;
		chess_pkg::rank_t r5;
		logic ks;
		logic qs;
		logic [7:0] tq;
		int t;

		bad = {7'b1000000, 6'o00, 6'o00};
		cb.pad = 8'h00;
		eb.pad = 8'h00;
		for (int i = 0; i < 8; i++) begin
			cb.slot[i] = bad;
			eb.slot[i] = bad;
		end
		r1 = b[0];
		r5 = b[4];

		ks = cr && r1[4].color == 1'b0 && r1[4].piece == chess_pkg::KING
			&& r1[5].piece == chess_pkg::EMPTY && r1[6].piece == chess_pkg::EMPTY
			&& r1[7].color == 1'b0 && r1[7].piece == chess_pkg::ROOK;
		qs = cl && r1[4].color == 1'b0 && r1[4].piece == chess_pkg::KING
			&& r1[1].piece == chess_pkg::EMPTY && r1[2].piece == chess_pkg::EMPTY
			&& r1[3].piece == chess_pkg::EMPTY
			&& r1[0].color == 1'b0 && r1[0].piece == chess_pkg::ROOK;
		if (ks)
			cb.slot[0] = {7'b0000010, 6'o40, 6'o60}; // e1 to g1
		if (qs)
			cb.slot[1] = {7'b0000010, 6'o40, 6'o20}; // e1 to c1
		cf = ks | qs;

		for (int f = 0; f < 8; f++)
			tq[f] = er[f] && r5[f].color == 1'b1 && r5[f].piece == chess_pkg::PAWN;
		ef = 1'b0;
		for (int k = 0; k < 4; k++) begin
			t = tq[2*k] ? 2*k : (tq[2*k+1] ? 2*k + 1 : -1);
			if (t > 0 && r5[t-1].color == 1'b0 && r5[t-1].piece == chess_pkg::PAWN) begin
				eb.slot[2*k] = {7'b0010101, 3'(t - 1), 3'd4, 3'(t), 3'd5};
				ef = 1'b1;
			end
			if (t >= 0 && t < 7 && r5[t+1].color == 1'b0 && r5[t+1].piece == chess_pkg::PAWN) begin
				eb.slot[2*k+1] = {7'b0010101, 3'(t + 1), 3'd4, 3'(t), 3'd5};
				ef = 1'b1;
			end
		end
	endfunction

	// biased so castling and en passant show up often
	task automatic make_position();
		for (int r = 0; r < 8; r++)
			for (int f = 0; f < 8; f++)
				board[r][f] = random_square();
		for (int f = 0; f < 8; f++) begin
			case (f)
				0, 7: begin
					if (rand_below(4) != 0)
						board[0][f] = make_square(chess_pkg::WHITE, chess_pkg::ROOK);
				end
				4: begin
					if (rand_below(4) != 0)
						board[0][f] = make_square(chess_pkg::WHITE, chess_pkg::KING);
				end
				default: begin
					if (rand_below(3) != 0)
						board[0][f] = make_square(chess_pkg::WHITE, chess_pkg::EMPTY);
				end
			endcase
			case (rand_below(3))
				0: board[4][f] = make_square(chess_pkg::WHITE, chess_pkg::PAWN);
				1: board[4][f] = make_square(chess_pkg::BLACK, chess_pkg::PAWN);
				default: board[4][f] = make_square(chess_pkg::WHITE, chess_pkg::EMPTY);
			endcase
		end
		castle_left  = (rand_below(4) != 0);
		castle_right = (rand_below(4) != 0);
		enp_rights   = 8'(rand_below(256));
	endtask

	initial begin : stimulus
		move_pkg::move_bundle_t cb;
		move_pkg::move_bundle_t eb;
		logic cf;
		logic ef;
		int n_castle;
		int n_enp;
		int n_left;

		seed = 32'h00e4_5c85;
		reset = 1'b1;
		board = '0;
		castle_left = 1'b0;
		castle_right = 1'b0;
		enp_rights = '0;
		rd_en = 1'b0;
		check_go = 1'b0;
		n_errors = 0;
		n_checks = 0;
		n_castle = 0;
		n_enp = 0;
		n_left = 0;
		for (int n = 0; n < NUM_POS; n++) begin
			@(posedge clk);
			#1;
			reset = 1'b1;
			make_position();
			ref_bundles(board, castle_left, castle_right, enp_rights, cb, eb, cf, ef);
			exp_q.delete();
			if (cf) begin
				exp_q.push_back(cb);
				n_castle++;
			end
			if (ef) begin
				exp_q.push_back(eb);
				n_enp++;
			end
			repeat (10) begin
				@(posedge clk);
				#1;
				n_checks++;
				if (fifo_empty !== 1'b1)
					report_bit("fifo_empty", 1'b1, fifo_empty);
				if (done !== 1'b0)
					report_bit("done", 1'b0, done);
			end
			reset = 1'b0;
			@(posedge clk); // E0, position captured
			#1;
			n_checks++;
			if (done !== 1'b0)
				report_bit("done", 1'b0, done);
			if (fifo_empty !== 1'b1)
				report_bit("fifo_empty", 1'b1, fifo_empty);
			@(posedge clk); // E1
			#1;
			if (done !== 1'b0)
				report_bit("done", 1'b0, done);
			if (fifo_empty !== !cf)
				report_bit("fifo_empty", !cf, fifo_empty);
			@(posedge clk); // E2
			#1;
			if (done !== 1'b1)
				report_bit("done", 1'b1, done);
			if (fifo_empty !== !(cf || ef))
				report_bit("fifo_empty", !(cf || ef), fifo_empty);
			if (n % 6 == 5 && exp_q.size() > 0) begin
				n_left++; // left in the fifo for the next reset
			end else begin
				check_go = 1'b1;
				wait (!check_go);
			end
		end
		@(posedge clk);
		#1;
		$display("positions %0d, castling %0d, en passant %0d, unread %0d, checks %0d, errors %0d",
			NUM_POS, n_castle, n_enp, n_left, n_checks, n_errors);
		if (n_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin : compare
		move_pkg::move_bundle_t exp_b;
		int gap;

		forever begin
			wait (check_go);
			if (exp_q.size() == 0) begin
				repeat (2) begin
					rd_en = 1'b1;
					@(posedge clk);
					#1;
					rd_en = 1'b0;
					n_checks++;
					if (fifo_empty !== 1'b1) begin
						n_errors++;
						$display("extra bundle at %0t: fifo not empty with no special moves", $time);
					end
				end
			end
			while (exp_q.size() > 0) begin
				exp_b = exp_q.pop_front();
				n_checks++;
				if (fifo_empty) begin
					n_errors++;
					$display("bundle missing at %0t: %0d expected bundle(s) not in the fifo",
						$time, exp_q.size() + 1);
					exp_q.delete();
				end else begin
					if (fifo_out !== exp_b)
						report_bundle("fifo_out", exp_b, fifo_out);
					gap = int'(rand_below(4));
					repeat (gap) begin
						@(posedge clk);
						#1;
						if (fifo_out !== exp_b)
							report_bundle("fifo_out", exp_b, fifo_out); // head moved while stalled
					end
					rd_en = 1'b1;
					@(posedge clk);
					#1;
					rd_en = 1'b0;
					if (done !== 1'b1)
						report_bit("done", 1'b1, done);
					if (exp_q.size() == 0 && fifo_empty !== 1'b1) begin
						n_errors++;
						$display("extra bundle at %0t: fifo not empty after the last pop", $time);
					end
				end
			end
			check_go = 1'b0;
		end
	end

	initial begin : watchdog
		#(NUM_POS * CYCLES_PER_POS * 10 * 2);
		$display("timeout at %0t: the run did not finish in time", $time);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- list.f
hw/chess_pkg.sv
hw/move_pkg.sv
hw/position_latch.sv
hw/castle_finder.sv
hw/en_passant_finder.sv
hw/move_sequencer.sv
hw/move_fifo.sv
hw/move_gen_top.sv
testbench/tb_move_gen.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_move_gen -f list.f -o tb_move_gen &&
./obj_dir/tb_move_gen | grep "Done: no errors" &&
exit 0 || exit 1
